// File: rtl/seq_cfg_pkg.sv
// Sizing constants shared by every block of the step sequencer
package seq_cfg_pkg;

    // Number of sequence slots that can be programmed
    localparam int max_steps = 5;

    // Number of start/done channel pairs on the output side
    localparam int n_channels = 5;

    // A step index must cover 0 to max_steps-1
    localparam int step_index_width = 3;

    // A channel selector can also name channels that do not exist
    // Such steps are passed over without a pulse
    localparam int channel_index_width = 3;

    // Width of a skip setting and of each per-step skip counter
    localparam int skip_width = 5;

    // The step delay and the timebase divider share one width
    localparam int delay_width = 16;

    // Width of the step-count field in the control register
    localparam int n_steps_width = 8;

endpackage

// File: rtl/seq_regmap_pkg.sv
// Register map of the programming port
package seq_regmap_pkg;

    // Address and data widths of the port
    localparam int reg_addr_width = 4;
    localparam int reg_data_width = 32;

    // Control register with the step count in the low byte
    localparam logic [reg_addr_width-1:0] addr_control = 4'd0;

    // Timebase divider, one tick every divider+1 clock cycles
    localparam logic [reg_addr_width-1:0] addr_timebase = 4'd1;

    // Inter-step delay, counted in timebase ticks
    localparam logic [reg_addr_width-1:0] addr_step_delay = 4'd2;

    // First of the per-step channel selectors, one register per step
    localparam logic [reg_addr_width-1:0] addr_step_channel_base = 4'd3;

    // First of the per-step skip settings, right after the channel block
    localparam logic [reg_addr_width-1:0] addr_skip_base =
        reg_addr_width'(3 + seq_cfg_pkg::max_steps);

    // Three fixed registers followed by two blocks of per-step registers
    localparam int n_registers = 3 + 2 * seq_cfg_pkg::max_steps;

    // Burst bit in the control register
    // The step count sits below it, starting at bit 0
    localparam int ctrl_burst_bit = 8;

endpackage

// File: rtl/seq_register_file.sv
`timescale 1ns/1ps

module seq_register_file import seq_cfg_pkg::*, seq_regmap_pkg::*; (
    input  logic                           clock,
    input  logic                           rst_n,
    input  logic                           reg_write,
    input  logic [reg_addr_width-1:0]      reg_addr,
    input  logic [reg_data_width-1:0]      reg_wdata,
    output logic [reg_data_width-1:0]      reg_rdata,
    output logic [n_steps_width-1:0]       n_steps,
    output logic                           burst_mode,
    output logic [delay_width-1:0]         timebase_divider,
    output logic [delay_width-1:0]         step_delay,
    output logic [channel_index_width-1:0] step_channel [max_steps],
    output logic [skip_width-1:0]          skip_setting [max_steps]
);

    // Keep the step count within 1 to max_steps so the engine never
    // indexes past the last slot
    function automatic logic [n_steps_width-1:0] clamp_steps(
        input logic [n_steps_width-1:0] raw
    );
        if (raw == '0) begin
            return n_steps_width'(1);
        end
        if (raw > n_steps_width'(max_steps)) begin
            return n_steps_width'(max_steps);
        end
        return raw;
    endfunction

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            // A cleared step count clamps to one, so that is what it holds
            n_steps          <= n_steps_width'(1);
            burst_mode       <= 1'b0;
            timebase_divider <= '0;
            step_delay       <= '0;
            for (int i = 0; i < max_steps; i++) begin
                step_channel[i] <= '0;
                skip_setting[i] <= '0;
            end
        end else if (reg_write) begin
            if (reg_addr == addr_control) begin
                n_steps    <= clamp_steps(reg_wdata[n_steps_width-1:0]);
                burst_mode <= reg_wdata[ctrl_burst_bit];
            end
            if (reg_addr == addr_timebase) begin
                timebase_divider <= reg_wdata[delay_width-1:0];
            end
            if (reg_addr == addr_step_delay) begin
                step_delay <= reg_wdata[delay_width-1:0];
            end
            // Per-step blocks are decoded slot by slot
            for (int i = 0; i < max_steps; i++) begin
                if (reg_addr == addr_step_channel_base + reg_addr_width'(i)) begin
                    step_channel[i] <= reg_wdata[channel_index_width-1:0];
                end
                if (reg_addr == addr_skip_base + reg_addr_width'(i)) begin
                    skip_setting[i] <= reg_wdata[skip_width-1:0];
                end
            end
        end
    end

    // Readback is combinational, and anything outside the map reads zero
    always_comb begin
        reg_rdata = '0;
        if (reg_addr == addr_control) begin
            reg_rdata[n_steps_width-1:0] = n_steps;
            reg_rdata[ctrl_burst_bit]    = burst_mode;
        end
        if (reg_addr == addr_timebase) begin
            reg_rdata[delay_width-1:0] = timebase_divider;
        end
        if (reg_addr == addr_step_delay) begin
            reg_rdata[delay_width-1:0] = step_delay;
        end
        for (int i = 0; i < max_steps; i++) begin
            if (reg_addr == addr_step_channel_base + reg_addr_width'(i)) begin
                reg_rdata[channel_index_width-1:0] = step_channel[i];
            end
            if (reg_addr == addr_skip_base + reg_addr_width'(i)) begin
                reg_rdata[skip_width-1:0] = skip_setting[i];
            end
        end
    end

endmodule

// File: rtl/seq_timebase.sv
`timescale 1ns/1ps

module seq_timebase import seq_cfg_pkg::*; (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic [delay_width-1:0] timebase_divider,
    input  logic                   tick_restart,
    output logic                   tick
);

    // Cycles elapsed since the last restart or tick
    logic [delay_width-1:0] prescale_count;

    // The tick is high during the cycle in which the count has reached the
    // divider, which gives one tick every divider+1 cycles
    // Greater-or-equal also catches a divider lowered below the running count
    assign tick = (prescale_count >= timebase_divider);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            prescale_count <= '0;
        end else if (tick_restart || tick) begin
            // A restart lines the first tick up with the start of a delay
            prescale_count <= '0;
        end else begin
            prescale_count <= prescale_count + 1'b1;
        end
    end

endmodule

// File: rtl/seq_skip_counters.sv
`timescale 1ns/1ps

module seq_skip_counters import seq_cfg_pkg::*; (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic [step_index_width-1:0] current_step,
    input  logic [skip_width-1:0]       skip_setting [max_steps],
    input  logic                        skip_eval,
    input  logic                        skip_clear,
    output logic                        step_fire
);

    // One pass counter per sequence slot
    logic [skip_width-1:0] pass_count [max_steps];

    // Target for the slot that is being evaluated
    logic [skip_width-1:0] skip_target;

    // Settings of 0 and 1 both mean fire on every pass
    // A setting of N otherwise lets N-1 passes go by before firing
    always_comb begin
        if (skip_setting[current_step] <= skip_width'(1)) begin
            skip_target = '0;
        end else begin
            skip_target = skip_setting[current_step] - 1'b1;
        end
    end

    // Greater-or-equal covers a setting lowered while a count was running
    assign step_fire = (pass_count[current_step] >= skip_target);

    always_ff @(posedge clock) begin
        if (!rst_n || skip_clear) begin
            for (int i = 0; i < max_steps; i++) begin
                pass_count[i] <= '0;
            end
        end else if (skip_eval) begin
            // A firing pass starts the count over, a skipped pass adds one
            if (step_fire) begin
                pass_count[current_step] <= '0;
            end else begin
                pass_count[current_step] <= pass_count[current_step] + 1'b1;
            end
        end
    end

endmodule

// File: rtl/seq_engine.sv
`timescale 1ns/1ps

module seq_engine import seq_cfg_pkg::*; (
    input  logic                           clock,
    input  logic                           rst_n,
    input  logic                           enable,
    input  logic [n_channels-1:0]          step_done,
    input  logic [n_steps_width-1:0]       n_steps,
    input  logic                           burst_mode,
    input  logic [delay_width-1:0]         step_delay,
    input  logic [channel_index_width-1:0] step_channel [max_steps],
    input  logic                           step_fire,
    input  logic                           tick,
    output logic [n_channels-1:0]          step_start,
    output logic [step_index_width-1:0]    current_step,
    output logic                           skip_eval,
    output logic                           skip_clear,
    output logic                           tick_restart
);

    typedef enum logic [1:0] {
        st_idle,
        st_start_step,
        st_wait_done,
        st_step_delay
    } state_t;

    state_t state;

    // Ticks seen since the current delay began
    logic [delay_width-1:0] delay_count;

    // Channel of the active step, decoded one-hot
    logic [channel_index_width-1:0] cur_channel;
    logic [n_channels-1:0]          channel_onehot;
    logic                           channel_valid;
    logic                           done_sel;
    logic                           last_step;
    logic                           step_goes_out;

    assign cur_channel = step_channel[current_step];

    // A selector past the last channel decodes to all zeros
    always_comb begin
        for (int i = 0; i < n_channels; i++) begin
            channel_onehot[i] = (cur_channel == channel_index_width'(i));
        end
    end

    assign channel_valid = (cur_channel < channel_index_width'(n_channels));

    // Only the done flag of the channel that was started counts
    assign done_sel = |(step_done & channel_onehot);

    // The step count is never zero, so the last slot is n_steps-1
    assign last_step = (n_steps_width'(current_step) + 1'b1) >= n_steps;

    // A step pulses only if it is due and its channel exists
    assign step_goes_out = step_fire && channel_valid;

    // Skip counters advance once per visit to start_step and clear when idle
    assign skip_eval  = (state == st_start_step);
    assign skip_clear = (state == st_idle);

    // Restart the timebase on every entry into the delay state, so the
    // first tick lands divider+1 cycles later
    assign tick_restart = ((state == st_wait_done) && done_sel) ||
                          ((state == st_start_step) && !step_goes_out);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state        <= st_idle;
            current_step <= '0;
            step_start   <= '0;
            delay_count  <= '0;
        end else begin
            // Start pulses last a single cycle
            step_start <= '0;
            case (state)
                st_idle: begin
                    current_step <= '0;
                    if (enable) begin
                        state <= st_start_step;
                    end
                end
                st_start_step: begin
                    delay_count <= '0;
                    if (step_goes_out) begin
                        step_start <= channel_onehot;
                        state      <= st_wait_done;
                    end else begin
                        // Skipped or unmapped steps count as done at once
                        state <= st_step_delay;
                    end
                end
                st_wait_done: begin
                    // No timeout, the engine waits as long as the channel needs
                    if (done_sel) begin
                        state <= st_step_delay;
                    end
                end
                st_step_delay: begin
                    if (delay_count >= step_delay) begin
                        if (last_step) begin
                            current_step <= '0;
                            state        <= burst_mode ? st_idle : st_start_step;
                        end else begin
                            current_step <= current_step + 1'b1;
                            state        <= st_start_step;
                        end
                    end else if (tick) begin
                        delay_count <= delay_count + 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

// File: rtl/seq_top.sv
`timescale 1ns/1ps

module seq_top import seq_cfg_pkg::*, seq_regmap_pkg::*; (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      reg_write,
    input  logic [reg_addr_width-1:0] reg_addr,
    input  logic [reg_data_width-1:0] reg_wdata,
    output logic [reg_data_width-1:0] reg_rdata,
    input  logic                      enable,
    output logic [n_channels-1:0]     step_start,
    input  logic [n_channels-1:0]     step_done
);

    // Configuration from the register file
    logic [n_steps_width-1:0]       n_steps;
    logic                           burst_mode;
    logic [delay_width-1:0]         timebase_divider;
    logic [delay_width-1:0]         step_delay;
    logic [channel_index_width-1:0] step_channel [max_steps];
    logic [skip_width-1:0]          skip_setting [max_steps];

    // Engine to timebase and skip counters
    logic                        tick_restart;
    logic                        tick;
    logic [step_index_width-1:0] current_step;
    logic                        skip_eval;
    logic                        skip_clear;
    logic                        step_fire;

    seq_register_file seq_register_file_inst (
        .clock            (clock),
        .rst_n            (rst_n),
        .reg_write        (reg_write),
        .reg_addr         (reg_addr),
        .reg_wdata        (reg_wdata),
        .reg_rdata        (reg_rdata),
        .n_steps          (n_steps),
        .burst_mode       (burst_mode),
        .timebase_divider (timebase_divider),
        .step_delay       (step_delay),
        .step_channel     (step_channel),
        .skip_setting     (skip_setting)
    );

    seq_timebase seq_timebase_inst (
        .clock            (clock),
        .rst_n            (rst_n),
        .timebase_divider (timebase_divider),
        .tick_restart     (tick_restart),
        .tick             (tick)
    );

    seq_skip_counters seq_skip_counters_inst (
        .clock        (clock),
        .rst_n        (rst_n),
        .current_step (current_step),
        .skip_setting (skip_setting),
        .skip_eval    (skip_eval),
        .skip_clear   (skip_clear),
        .step_fire    (step_fire)
    );

    seq_engine seq_engine_inst (
        .clock        (clock),
        .rst_n        (rst_n),
        .enable       (enable),
        .step_done    (step_done),
        .n_steps      (n_steps),
        .burst_mode   (burst_mode),
        .step_delay   (step_delay),
        .step_channel (step_channel),
        .step_fire    (step_fire),
        .tick         (tick),
        .step_start   (step_start),
        .current_step (current_step),
        .skip_eval    (skip_eval),
        .skip_clear   (skip_clear),
        .tick_restart (tick_restart)
    );

endmodule

// File: tests/seq_tb.sv
`timescale 1ns/1ps

module seq_tb import seq_cfg_pkg::*, seq_regmap_pkg::*;;

    // About ten times the longest estimate for the whole run
    localparam int cycle_limit = 20000;

    logic                      clock = 1'b0;
    logic                      rst_n;
    logic                      reg_write;
    logic [reg_addr_width-1:0] reg_addr;
    logic [reg_data_width-1:0] reg_wdata;
    logic [reg_data_width-1:0] reg_rdata;
    logic                      enable;
    logic [n_channels-1:0]     step_start;
    logic [n_channels-1:0]     step_done;

    int cycle = 0;
    int checks = 0;
    int errors = 0;
    logic zero_wait = 1'b0;
    logic [15:0] lfsr_state = 16'd41697;

    // Pulses seen by the monitor, done edges from the responder, and the scoreboard
    int seen_channels[$];
    int seen_cycles[$];
    int done_edges[$];
    int expected_channels[$];

    int burst_map[4] = '{3, 0, 4, 1};
    int gap_delays[5] = '{0, 1, 2, 3, 1};
    int gap_dividers[5] = '{0, 0, 3, 1, 5};
    int skip_map[3] = '{1, 3, 2};

    seq_top seq_top_inst (
        .clock      (clock),
        .rst_n      (rst_n),
        .reg_write  (reg_write),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .enable     (enable),
        .step_start (step_start),
        .step_done  (step_done)
    );

    always #20 clock = ~clock;

    // After edge k the counter holds k, which is how every edge is numbered here
    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            $display("Timeout: the run passed %0d cycles without finishing", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic feedback;
        feedback = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], feedback};
    endfunction

    task automatic draw_random_wait(output int value);
        value = 0;
        for (int b = 0; b < 3; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    function automatic int onehot_index(input logic [n_channels-1:0] bits);
        for (int i = 0; i < n_channels; i++) begin
            if (bits[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    // Settings 0 and 1 fire every pass, N fires every Nth pass
    function automatic int every_nth(input int setting);
        return (setting <= 1) ? 1 : setting;
    endfunction

    function automatic int count_channel(input int ch);
        int n;
        n = 0;
        foreach (seen_channels[i]) begin
            if (seen_channels[i] == ch) begin
                n++;
            end
        end
        return n;
    endfunction

    // All inputs change 1 ns after the rising edge
    task automatic step_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic run_cycles(input int n);
        repeat (n) step_cycle();
    endtask

    task automatic expect_equal(input string what, input int got, input int expected);
        checks++;
        assert (got == expected) else begin
            $display("[FAIL] %0t %s: got 'h%0h, expected 'h%0h", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic write_reg(input int addr, input logic [reg_data_width-1:0] data);
        reg_write = 1'b1;
        reg_addr  = reg_addr_width'(addr);
        reg_wdata = data;
        step_cycle();
        reg_write = 1'b0;
    endtask

    // The read port is combinational, so the word is checked after it settles
    task automatic check_read(input int addr, input int expected);
        reg_addr = reg_addr_width'(addr);
        #1;
        expect_equal($sformatf("readback of register %0d", addr), int'(reg_rdata), expected);
    endtask

    task automatic program_step(input int idx, input int channel, input int skip);
        write_reg(int'(addr_step_channel_base) + idx, reg_data_width'(channel));
        write_reg(int'(addr_skip_base) + idx, reg_data_width'(skip));
    endtask

    task automatic program_timing(input int divider, input int delay);
        write_reg(int'(addr_timebase), reg_data_width'(divider));
        write_reg(int'(addr_step_delay), reg_data_width'(delay));
    endtask

    task automatic clear_records();
        seen_channels.delete();
        seen_cycles.delete();
        done_edges.delete();
        expected_channels.delete();
    endtask

    // Enable is high for one edge only, and that edge is returned
    task automatic fire_enable(output int enable_edge);
        enable = 1'b1;
        enable_edge = cycle + 1;
        step_cycle();
        enable = 1'b0;
    endtask

    task automatic wait_pulses(input int n);
        while (seen_channels.size() < n) begin
            step_cycle();
        end
    endtask

    task automatic compare_order(input string what);
        expect_equal({what, " pulse count"}, seen_channels.size(), expected_channels.size());
        for (int i = 0; i < expected_channels.size() && i < seen_channels.size(); i++) begin
            expect_equal({what, " channel"}, seen_channels[i], expected_channels[i]);
        end
    endtask

    // A start pulse never lasts longer than one cycle
    assert property (@(posedge clock) disable iff (!rst_n)
        !((step_start != '0) && ($past(step_start) != '0)))
    else begin
        $display("[FAIL] %0t start pulse held high for more than one cycle", $time);
        errors++;
    end

    // Pulses are recorded on the falling edge, where step_start is stable
    always @(negedge clock) begin
        if (rst_n && step_start != '0) begin
            checks++;
            assert ($onehot(step_start)) else begin
                $display("[FAIL] %0t start pulse has %0d bits set", $time,
                         $countones(step_start));
                errors++;
            end
            seen_channels.push_back(onehot_index(step_start));
            seen_cycles.push_back(cycle);
        end
    end

    // Answers each start pulse with a one-cycle done on the same channel
    initial begin : done_responder
        int wait_cycles;
        logic [n_channels-1:0] channel_bits;
        step_done = '0;
        forever begin
            step_cycle();
            if (step_start != '0) begin
                channel_bits = step_start;
                wait_cycles = 0;
                if (!zero_wait) begin
                    draw_random_wait(wait_cycles);
                end
                run_cycles(wait_cycles);
                step_done = channel_bits;
                // The engine samples this done at the next edge
                done_edges.push_back(cycle + 1);
                step_cycle();
                step_done = '0;
            end
        end
    end

    initial begin
        int start_edge;
        int span;
        rst_n     = 1'b0;
        reg_write = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        enable    = 1'b0;
        run_cycles(10);
        rst_n = 1'b1;
        step_cycle();

        // Reset step count reads as 1, then 0 clamps up and 9 clamps down
        check_read(int'(addr_control), 'h001);
        write_reg(int'(addr_control), 32'h000);
        check_read(int'(addr_control), 'h001);
        write_reg(int'(addr_control), 32'h109);
        check_read(int'(addr_control), 'h105);
        program_timing('hA5C3, 'h0F0F);
        check_read(int'(addr_timebase), 'hA5C3);
        check_read(int'(addr_step_delay), 'h0F0F);
        for (int i = 0; i < max_steps; i++) begin
            program_step(i, (i + 2) % 8, 7 * i + 3);
        end
        for (int i = 0; i < max_steps; i++) begin
            check_read(int'(addr_step_channel_base) + i, (i + 2) % 8);
            check_read(int'(addr_skip_base) + i, 7 * i + 3);
        end
        // Writes outside the map are dropped, so those addresses still read zero
        for (int a = n_registers; a < 16; a++) begin
            write_reg(a, 32'hFFFF_FFFF);
            check_read(a, 0);
        end

        // Burst of four run twice, so the second enable proves the engine went idle
        write_reg(int'(addr_control), 32'h104);
        program_timing(1, 1);
        for (int i = 0; i < 4; i++) begin
            program_step(i, burst_map[i], 0);
        end
        for (int run = 0; run < 2; run++) begin
            clear_records();
            foreach (burst_map[i]) begin
                expected_channels.push_back(burst_map[i]);
            end
            fire_enable(start_edge);
            wait_pulses(4);
            expect_equal("first pulse latency", seen_cycles[0], start_edge + 1);
            run_cycles(40);
            compare_order("burst");
        end

        // Gap from the sampled done to the next pulse for several timebases
        zero_wait = 1'b1;
        write_reg(int'(addr_control), 32'h102);
        program_step(0, 0, 0);
        program_step(1, 1, 0);
        for (int k = 0; k < 5; k++) begin
            span = gap_delays[k] * (gap_dividers[k] + 1);
            program_timing(gap_dividers[k], gap_delays[k]);
            clear_records();
            fire_enable(start_edge);
            wait_pulses(2);
            expect_equal("inter-step gap", seen_cycles[1], done_edges[0] + 2 + span);
            run_cycles(span + 10);
        end

        // Channel 6 does not exist, so its step passes silently with the same delay
        write_reg(int'(addr_control), 32'h103);
        program_step(0, 2, 0);
        program_step(1, 6, 0);
        program_step(2, 4, 0);
        program_timing(1, 2);
        clear_records();
        expected_channels.push_back(2);
        expected_channels.push_back(4);
        fire_enable(start_edge);
        wait_pulses(2);
        expect_equal("gap across unmapped step", seen_cycles[1], done_edges[0] + 4 + 2 * 4);
        run_cycles(30);
        compare_order("unmapped channel");

        // Continuous mode over twelve passes with step k driving channel k
        zero_wait = 1'b0;
        write_reg(int'(addr_control), 32'h003);
        program_timing(0, 0);
        for (int k = 0; k < 3; k++) begin
            program_step(k, k, skip_map[k]);
        end
        clear_records();
        for (int p = 1; p <= 12; p++) begin
            for (int k = 0; k < 3; k++) begin
                if (p % every_nth(skip_map[k]) == 0) begin
                    expected_channels.push_back(k);
                end
            end
        end
        fire_enable(start_edge);
        wait_pulses(expected_channels.size());
        compare_order("pulse skipping");
        for (int k = 0; k < 3; k++) begin
            expect_equal("fires per step", count_channel(k), 12 / every_nth(skip_map[k]));
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
rtl/seq_cfg_pkg.sv
rtl/seq_regmap_pkg.sv
rtl/seq_register_file.sv
rtl/seq_timebase.sv
rtl/seq_skip_counters.sv
rtl/seq_engine.sv
rtl/seq_top.sv
tests/seq_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the step sequencer testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f src.f \
    --top-module seq_tb \
    --Mdir obj_dir \
    -o seq_tb_sim

./obj_dir/seq_tb_sim > sim.log 2>&1 || true
cat sim.log

# The log decides the result, not the simulator's exit status
if grep -q "^TESTBENCH PASSED$" sim.log; then
    echo "Simulation result: pass"
    exit 0
else
    echo "Simulation result: fail"
    exit 1
fi
